// File: dv/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
  parameter int SEED = 8066
) (
  input  wire         clock,
  input  wire         rst_n_sync,
  input  wire         i_arvalid,
  output logic        o_arready,
  input  wire  [31:0] i_araddr,
  input  wire  [7:0]  i_arlen,
  output logic        o_rvalid,
  input  wire         i_rready,
  output logic [31:0] o_rdata,
  output logic        o_rlast
);

  integer      seed;
  logic        busy;
  logic [31:0] burst_addr;
  int          beats_left;

  // Upper half inverts the low 16 bits of the word address
  function automatic logic [31:0] word_at(input logic [31:0] byte_addr);
    logic [15:0] low;
    low = byte_addr[17:2];
    return {~low, low};
  endfunction

  // Three chances in four to move on in a given cycle
  function automatic logic roll_go();
    return ($unsigned($random(seed)) % 4) != 0;
  endfunction

  initial begin
    seed       = SEED;
    busy       = 1'b0;
    burst_addr = '0;
    beats_left = 0;
    o_arready  = 1'b0;
    o_rvalid   = 1'b0;
    o_rdata    = '0;
    o_rlast    = 1'b0;
  end

  // ARVALID and RREADY come from DUT state, so a handshake offered here completes
  // on the next rising edge
  always @(negedge clock) begin
    o_arready = 1'b0;
    o_rvalid  = 1'b0;
    o_rlast   = 1'b0;
    if (!rst_n_sync) begin
      busy = 1'b0;
    end else if (!busy) begin
      if (i_arvalid && roll_go()) begin
        o_arready  = 1'b1;
        busy       = 1'b1;
        burst_addr = i_araddr;
        beats_left = int'(i_arlen) + 1;
      end
    end else if (i_rready && roll_go()) begin
      o_rvalid   = 1'b1;
      o_rdata    = word_at(burst_addr);
      o_rlast    = (beats_left == 1);
      burst_addr = burst_addr + 32'd4;
      beats_left = beats_left - 1;
      busy       = (beats_left != 0);
    end
  end

endmodule

`default_nettype wire

// File: dv/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam int          CLK_PERIOD = 100;
  localparam logic [31:0] RESET_PC   = 32'h3000_0000;
  localparam int          INDEX_BITS = 4;
  localparam int          LINE_WORDS = 4;
  localparam int          NUM_TESTS  = 5;
  // About 2000 cycles per test of up to 40 instructions
  localparam int          WATCHDOG_CYCLES = 2000 * NUM_TESTS;
  localparam logic [31:0] LINE_MASK  = LINE_WORDS * 4 - 1;
  localparam logic [31:0] REUSE_PC   = 32'h5000_0120;

  wire         clock;
  wire         rst_n_sync;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic        inst_ready;
  wire         inst_valid;
  wire  [31:0] inst;
  wire  [31:0] inst_pc;
  wire         arvalid;
  wire         arready;
  wire  [31:0] araddr;
  wire  [7:0]  arlen;
  wire         rvalid;
  wire         rready;
  wire  [31:0] rdata;
  wire         rlast;

  integer      seed;
  int          ready_pct;
  int          errors;
  int          checks;
  int          delivered;
  int          ar_count;
  int          test_num;
  int          test_err_base;
  int          mark;
  int          ar_snap;
  logic [31:0] exp_pc;
  logic        pend;
  logic [31:0] pend_pc;
  logic        hold_prev;
  logic [31:0] prev_inst;
  logic [31:0] prev_pc;
  logic        burst_open;
  logic        ar_wait;
  logic [31:0] targets [4];

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) clock_gen_i (
    .o_clock      (clock),
    .o_rst_n_sync (rst_n_sync)
  );

  axi_mem_model #(.SEED(8066)) mem_i (
    .clock      (clock),
    .rst_n_sync (rst_n_sync),
    .i_arvalid  (arvalid),
    .o_arready  (arready),
    .i_araddr   (araddr),
    .i_arlen    (arlen),
    .o_rvalid   (rvalid),
    .i_rready   (rready),
    .o_rdata    (rdata),
    .o_rlast    (rlast)
  );

  fetch_top #(
    .RESET_PC   (RESET_PC),
    .INDEX_BITS (INDEX_BITS),
    .LINE_WORDS (LINE_WORDS)
  ) dut_i (
    .clock            (clock),
    .rst_n_sync       (rst_n_sync),
    .i_redirect_valid (redirect_valid),
    .i_redirect_pc    (redirect_pc),
    .o_inst_valid     (inst_valid),
    .i_inst_ready     (inst_ready),
    .o_inst           (inst),
    .o_inst_pc        (inst_pc),
    .o_arvalid        (arvalid),
    .i_arready        (arready),
    .o_araddr         (araddr),
    .o_arlen          (arlen),
    .i_rvalid         (rvalid),
    .o_rready         (rready),
    .i_rdata          (rdata),
    .i_rlast          (rlast)
  );

  function automatic logic [31:0] expected_inst(input logic [31:0] pc);
    logic [15:0] word;
    word = pc[17:2];
    return {~word, word};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic wait_count(input int target);
    while (delivered < target) begin
      @(negedge clock);
    end
  endtask

  task automatic send_redirect(input logic [31:0] target);
    redirect_valid = 1'b1;
    redirect_pc    = target;
    @(negedge clock);
    redirect_valid = 1'b0;
  endtask

  task automatic finish_test(input string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name, errors - test_err_base);
    test_err_base = errors;
  endtask

  always @(negedge clock) begin
    inst_ready = ($unsigned($random(seed)) % 100) < ready_pct;
  end

  // Reference model and bus protocol tracking
  always @(posedge clock) begin
    if (rst_n_sync) begin
      if (arvalid) begin
        compare_value("o_araddr", araddr, araddr & ~LINE_MASK);
        compare_value("o_arlen", 32'(arlen), LINE_WORDS - 1);
      end
      if (ar_wait) begin
        compare_value("o_arvalid", 32'(arvalid), 32'd1);
      end
      compare_value("o_rready", 32'(rready), 32'(burst_open));
      if (arvalid && arready) begin
        ar_count++;
        burst_open = 1'b1;
      end
      if (rvalid && rready && rlast) begin
        burst_open = 1'b0;
      end
      ar_wait = arvalid && !arready;
      if (hold_prev) begin
        compare_value("o_inst_valid", 32'(inst_valid), 32'd1);
        compare_value("o_inst", inst, prev_inst);
        compare_value("o_inst_pc", inst_pc, prev_pc);
      end
      if (inst_valid && inst_ready) begin
        compare_value("o_inst_pc", inst_pc, exp_pc);
        compare_value("o_inst", inst, expected_inst(exp_pc));
        delivered++;
        // Held redirect beats a new one which beats sequential
        if (pend) begin
          exp_pc = pend_pc;
        end else if (redirect_valid) begin
          exp_pc = redirect_pc;
        end else begin
          exp_pc = exp_pc + 32'd4;
        end
        pend = 1'b0;
      end else if (redirect_valid) begin
        pend    = 1'b1;
        pend_pc = redirect_pc;
      end
      hold_prev = inst_valid && !inst_ready;
      prev_inst = inst;
      prev_pc   = inst_pc;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with %0d instructions delivered",
             WATCHDOG_CYCLES, delivered);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    seed           = 8066;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    inst_ready     = 1'b0;
    ready_pct      = 100;
    errors         = 0;
    checks         = 0;
    delivered      = 0;
    ar_count       = 0;
    test_num       = 0;
    test_err_base  = 0;
    exp_pc         = RESET_PC;
    pend           = 1'b0;
    pend_pc        = '0;
    hold_prev      = 1'b0;
    prev_inst      = '0;
    prev_pc        = '0;
    burst_open     = 1'b0;
    ar_wait        = 1'b0;
    targets[0]     = 32'h3000_0208;
    targets[1]     = 32'h4000_0014;
    targets[2]     = 32'h3000_0040;
    targets[3]     = 32'h3000_0ffc;

    wait (rst_n_sync);
    wait_count(1);
    finish_test("reset_vector");

    ready_pct = 60;
    wait_count(delivered + 40);
    finish_test("sequential");

    ready_pct = 70;
    for (int i = 0; i < 4; i++) begin
      mark = delivered;
      send_redirect(targets[i]);
      wait_count(mark + 8);
    end
    finish_test("redirect");

    ready_pct = 20;
    wait_count(delivered + 30);
    finish_test("backpressure");

    // First pass loads the line and the second pass must hit
    ready_pct = 80;
    mark = delivered;
    send_redirect(REUSE_PC);
    wait_count(mark + 1 + LINE_WORDS);
    mark = delivered;
    send_redirect(REUSE_PC);
    wait_count(mark + 1);
    ar_snap = ar_count;
    wait_count(mark + 1 + LINE_WORDS);
    checks++;
    assert (ar_count == ar_snap) else begin
      $display("Cached line at %h was read from memory again", REUSE_PC);
      errors++;
    end
    finish_test("line_reuse");

    $display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic o_clock,
  output logic o_rst_n_sync
);

  initial begin
    o_clock = 1'b0;
    forever #(PERIOD_NS / 2) o_clock = ~o_clock;
  end

  // Two rising edges in reset, released on a falling edge
  initial begin
    o_rst_n_sync = 1'b0;
    repeat (2) @(posedge o_clock);
    @(negedge o_clock);
    o_rst_n_sync = 1'b1;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/fetch_pkg.sv
logic/bus_pkg.sv
logic/pc_sequencer.sv
logic/fetch_unit.sv
logic/icache.sv
logic/line_refill.sv
logic/fetch_top.sv
dv/tb_clock_gen.sv
dv/axi_mem_model.sv
dv/fetch_tb.sv

// File: logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // AXI4 read address
  typedef logic [31:0] bus_addr_t;

  // One R channel beat
  typedef logic [31:0] bus_data_t;

  // ARLEN, beats minus one
  typedef logic [7:0] burst_len_t;

  typedef enum logic [1:0] {
    REFILL_IDLE = 2'd0,
    REFILL_ADDR = 2'd1,
    REFILL_DATA = 2'd2
  } refill_state_e;

endpackage

`default_nettype wire

// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Instruction address
  typedef logic [31:0] pc_t;

  // Raw instruction word as returned by the cache
  typedef logic [31:0] inst_t;

  // Idle issues the pending address to the cache
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_WAIT = 2'd1,
    FETCH_HOLD = 2'd2
  } fetch_state_e;

  // Respond is the single cycle that the answer is valid
  typedef enum logic [1:0] {
    CACHE_LOOKUP  = 2'd0,
    CACHE_REFILL  = 2'd1,
    CACHE_RESPOND = 2'd2
  } cache_state_e;

endpackage

`default_nettype wire

// File: logic/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*, bus_pkg::*; #(
  parameter pc_t RESET_PC   = 32'h3000_0000,
  parameter int  INDEX_BITS = 4,
  parameter int  LINE_WORDS = 4
) (
  input  wire             clock,
  input  wire             rst_n_sync,
  input  wire             i_redirect_valid,
  input  wire pc_t        i_redirect_pc,
  output logic            o_inst_valid,
  input  wire             i_inst_ready,
  output inst_t           o_inst,
  output pc_t             o_inst_pc,
  output logic            o_arvalid,
  input  wire             i_arready,
  output bus_addr_t       o_araddr,
  output burst_len_t      o_arlen,
  input  wire             i_rvalid,
  output logic            o_rready,
  input  wire bus_data_t  i_rdata,
  input  wire             i_rlast
);

  localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);

  logic                     pc_update;
  pc_t                      pc_next;
  logic                     req;
  pc_t                      req_addr;
  logic                     cache_valid;
  inst_t                    cache_ins;
  logic                     refill_start;
  bus_addr_t                refill_addr;
  logic                     word_valid;
  logic [WORD_IDX_BITS-1:0] word_idx;
  bus_data_t                word_data;
  logic                     refill_done;

  pc_sequencer pc_sequencer_i (
    .clock            (clock),
    .rst_n_sync       (rst_n_sync),
    .i_post_valid     (o_inst_valid),
    .i_post_ready     (i_inst_ready),
    .i_pc             (o_inst_pc),
    .i_redirect_valid (i_redirect_valid),
    .i_redirect_pc    (i_redirect_pc),
    .o_pc_update      (pc_update),
    .o_pc_next        (pc_next)
  );

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) fetch_unit_i (
    .clock         (clock),
    .rst_n_sync    (rst_n_sync),
    .i_pc_update   (pc_update),
    .i_pc_next     (pc_next),
    .i_post_ready  (i_inst_ready),
    .o_post_valid  (o_inst_valid),
    .o_ins         (o_inst),
    .o_pc          (o_inst_pc),
    .o_req         (req),
    .o_req_addr    (req_addr),
    .i_cache_valid (cache_valid),
    .i_cache_ins   (cache_ins)
  );

  icache #(
    .INDEX_BITS (INDEX_BITS),
    .LINE_WORDS (LINE_WORDS)
  ) icache_i (
    .clock          (clock),
    .rst_n_sync     (rst_n_sync),
    .i_req          (req),
    .i_req_addr     (req_addr),
    .o_cache_valid  (cache_valid),
    .o_cache_ins    (cache_ins),
    .o_refill_start (refill_start),
    .o_refill_addr  (refill_addr),
    .i_word_valid   (word_valid),
    .i_word_idx     (word_idx),
    .i_word_data    (word_data),
    .i_refill_done  (refill_done)
  );

  line_refill #(
    .LINE_WORDS (LINE_WORDS)
  ) line_refill_i (
    .clock        (clock),
    .rst_n_sync   (rst_n_sync),
    .i_start      (refill_start),
    .i_line_addr  (refill_addr),
    .o_word_valid (word_valid),
    .o_word_idx   (word_idx),
    .o_word_data  (word_data),
    .o_done       (refill_done),
    .o_arvalid    (o_arvalid),
    .i_arready    (i_arready),
    .o_araddr     (o_araddr),
    .o_arlen      (o_arlen),
    .i_rvalid     (i_rvalid),
    .o_rready     (o_rready),
    .i_rdata      (i_rdata),
    .i_rlast      (i_rlast)
  );

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*; #(
  parameter pc_t RESET_PC = 32'h3000_0000
) (
  input  wire        clock,
  input  wire        rst_n_sync,
  input  wire        i_pc_update,
  input  wire pc_t   i_pc_next,
  input  wire        i_post_ready,
  output logic       o_post_valid,
  output inst_t      o_ins,
  output pc_t        o_pc,
  output logic       o_req,
  output pc_t        o_req_addr,
  input  wire        i_cache_valid,
  input  wire inst_t i_cache_ins
);

  fetch_state_e state_q;
  fetch_state_e state_d;
  pc_t          req_addr_q;
  inst_t        ins_q;
  pc_t          pc_q;
  logic         accept;

  assign accept = o_post_valid && i_post_ready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        state_d = FETCH_WAIT;
      end
      FETCH_WAIT: begin
        if (i_cache_valid) begin
          state_d = FETCH_HOLD;
        end
      end
      FETCH_HOLD: begin
        if (accept) begin
          state_d = FETCH_IDLE;
        end
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  // Fetch address starts at the reset vector
  always_ff @(posedge clock) begin
    if (!rst_n_sync) begin
      state_q    <= FETCH_IDLE;
      req_addr_q <= RESET_PC;
    end else begin
      state_q <= state_d;
      if (i_pc_update) begin
        req_addr_q <= i_pc_next;
      end
    end
  end

  // Answer and its address stay put until decode takes them
  always_ff @(posedge clock) begin
    if (state_q == FETCH_WAIT && i_cache_valid) begin
      ins_q <= i_cache_ins;
      pc_q  <= req_addr_q;
    end
  end

  assign o_req        = (state_q == FETCH_IDLE);
  assign o_req_addr   = req_addr_q;
  assign o_post_valid = (state_q == FETCH_HOLD);
  assign o_ins        = ins_q;
  assign o_pc         = pc_q;

endmodule

`default_nettype wire

// File: logic/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache import fetch_pkg::*, bus_pkg::*; #(
  parameter int INDEX_BITS = 4,
  parameter int LINE_WORDS = 4
) (
  input  wire                            clock,
  input  wire                            rst_n_sync,
  input  wire                            i_req,
  input  wire pc_t                       i_req_addr,
  output logic                           o_cache_valid,
  output inst_t                          o_cache_ins,
  output logic                           o_refill_start,
  output bus_addr_t                      o_refill_addr,
  input  wire                            i_word_valid,
  input  wire [$clog2(LINE_WORDS)-1:0]   i_word_idx,
  input  wire bus_data_t                 i_word_data,
  input  wire                            i_refill_done
);

  localparam int SETS        = 1 << INDEX_BITS;
  localparam int OFFSET_BITS = $clog2(LINE_WORDS);
  localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS - 2;

  cache_state_e state_q;
  logic         refill_start_q;
  logic [SETS-1:0] valid_q;

  // Tag and data arrays
  logic [TAG_BITS-1:0] tag_mem  [SETS];
  inst_t               data_mem [SETS*LINE_WORDS];

  logic [TAG_BITS-1:0]    req_tag;
  logic [INDEX_BITS-1:0]  req_index;
  logic [OFFSET_BITS-1:0] req_offset;
  logic                   hit;

  // Request held over a refill
  pc_t                    miss_addr_q;
  logic [TAG_BITS-1:0]    miss_tag;
  logic [INDEX_BITS-1:0]  miss_index;
  logic [OFFSET_BITS-1:0] miss_offset;
  inst_t                  rd_data_q;

  // Word address split, bits 1:0 are always zero
  assign req_offset = i_req_addr[2 +: OFFSET_BITS];
  assign req_index  = i_req_addr[2 + OFFSET_BITS +: INDEX_BITS];
  assign req_tag    = i_req_addr[31 -: TAG_BITS];

  assign miss_offset = miss_addr_q[2 +: OFFSET_BITS];
  assign miss_index  = miss_addr_q[2 + OFFSET_BITS +: INDEX_BITS];
  assign miss_tag    = miss_addr_q[31 -: TAG_BITS];

  // Tag compare in the request cycle
  assign hit = valid_q[req_index] && (tag_mem[req_index] == req_tag);

  always_ff @(posedge clock) begin
    if (!rst_n_sync) begin
      state_q        <= CACHE_LOOKUP;
      refill_start_q <= 1'b0;
      valid_q        <= '0;
    end else begin
      refill_start_q <= 1'b0;
      case (state_q)
        CACHE_LOOKUP: begin
          if (i_req && hit) begin
            state_q <= CACHE_RESPOND;
          end else if (i_req) begin
            state_q        <= CACHE_REFILL;
            refill_start_q <= 1'b1;
          end
        end
        CACHE_REFILL: begin
          if (i_refill_done) begin
            state_q             <= CACHE_RESPOND;
            valid_q[miss_index] <= 1'b1;
          end
        end
        CACHE_RESPOND: begin
          state_q <= CACHE_LOOKUP;
        end
        default: begin
          state_q <= CACHE_LOOKUP;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == CACHE_LOOKUP && i_req) begin
      miss_addr_q <= i_req_addr;
      rd_data_q   <= data_mem[{req_index, req_offset}];
    end
    // Beats land in the line as they arrive
    if (state_q == CACHE_REFILL && i_word_valid) begin
      data_mem[{miss_index, i_word_idx}] <= inst_t'(i_word_data);
    end
    if (state_q == CACHE_REFILL && i_refill_done) begin
      tag_mem[miss_index] <= miss_tag;
      rd_data_q           <= data_mem[{miss_index, miss_offset}];
    end
  end

  assign o_cache_valid  = (state_q == CACHE_RESPOND);
  assign o_cache_ins    = rd_data_q;
  assign o_refill_start = refill_start_q;

  // Line aligned, so the burst starts at word zero
  assign o_refill_addr = bus_addr_t'({miss_addr_q[31:2 + OFFSET_BITS],
                                      {(OFFSET_BITS + 2){1'b0}}});

endmodule

`default_nettype wire

// File: logic/line_refill.sv
`timescale 1ns/1ps
`default_nettype none

module line_refill import bus_pkg::*; #(
  parameter int LINE_WORDS = 4
) (
  input  wire                            clock,
  input  wire                            rst_n_sync,
  input  wire                            i_start,
  input  wire bus_addr_t                 i_line_addr,
  output logic                           o_word_valid,
  output logic [$clog2(LINE_WORDS)-1:0]  o_word_idx,
  output bus_data_t                      o_word_data,
  output logic                           o_done,
  output logic                           o_arvalid,
  input  wire                            i_arready,
  output bus_addr_t                      o_araddr,
  output burst_len_t                     o_arlen,
  input  wire                            i_rvalid,
  output logic                           o_rready,
  input  wire bus_data_t                 i_rdata,
  input  wire                            i_rlast
);

  refill_state_e                  state_q;
  bus_addr_t                      araddr_q;
  logic [$clog2(LINE_WORDS)-1:0]  beat_q;
  logic                           done_q;
  logic                           beat;

  assign beat = (state_q == REFILL_DATA) && i_rvalid;

  always_ff @(posedge clock) begin
    if (!rst_n_sync) begin
      state_q <= REFILL_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= beat && i_rlast;
      case (state_q)
        REFILL_IDLE: begin
          if (i_start) begin
            state_q <= REFILL_ADDR;
          end
        end
        REFILL_ADDR: begin
          if (i_arready) begin
            state_q <= REFILL_DATA;
          end
        end
        REFILL_DATA: begin
          // RLAST closes the burst
          if (beat && i_rlast) begin
            state_q <= REFILL_IDLE;
          end
        end
        default: begin
          state_q <= REFILL_IDLE;
        end
      endcase
    end
  end

  // Beat counter gives the word slot within the line
  always_ff @(posedge clock) begin
    if (state_q == REFILL_IDLE && i_start) begin
      araddr_q <= i_line_addr;
      beat_q   <= '0;
    end else if (beat) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // Always an INCR burst of one full line
  assign o_arvalid    = (state_q == REFILL_ADDR);
  assign o_araddr     = araddr_q;
  assign o_arlen      = burst_len_t'(LINE_WORDS - 1);
  assign o_rready     = (state_q == REFILL_DATA);
  assign o_word_valid = beat;
  assign o_word_idx   = beat_q;
  assign o_word_data  = i_rdata;
  assign o_done       = done_q;

endmodule

`default_nettype wire

// File: logic/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer import fetch_pkg::*; (
  input  wire        clock,
  input  wire        rst_n_sync,
  input  wire        i_post_valid,
  input  wire        i_post_ready,
  input  wire pc_t   i_pc,
  input  wire        i_redirect_valid,
  input  wire pc_t   i_redirect_pc,
  output logic       o_pc_update,
  output pc_t        o_pc_next
);

  logic handshake;
  logic redirect_pending_q;
  pc_t  redirect_pc_q;

  assign handshake = i_post_valid && i_post_ready;

  always_ff @(posedge clock) begin
    if (!rst_n_sync) begin
      redirect_pending_q <= 1'b0;
    end else if (handshake) begin
      redirect_pending_q <= 1'b0;
    end else if (i_redirect_valid) begin
      redirect_pending_q <= 1'b1;
    end
  end

  // A later redirect replaces an older one still waiting
  always_ff @(posedge clock) begin
    if (!handshake && i_redirect_valid) begin
      redirect_pc_q <= i_redirect_pc;
    end
  end

  assign o_pc_update = handshake;

  always_comb begin
    if (redirect_pending_q) begin
      o_pc_next = redirect_pc_q;
    end else if (i_redirect_valid) begin
      o_pc_next = i_redirect_pc;
    end else begin
      o_pc_next = i_pc + 32'd4;
    end
  end

endmodule

`default_nettype wire
